// File: list.f
source/axi_rb_pkg.sv
source/rb_fifo.sv
source/axi_read_burst_buffer.sv
source/axi_burst_mem.sv
source/axi_rb_subsys.sv
test/axi_rb_checker.sv
test/tb_axi_rb_subsys.sv

// File: Bender.yml
package:
  name: axi_rb_subsys

dependencies: {}

sources:
  # design
  - source/axi_rb_pkg.sv
  - source/rb_fifo.sv
  - source/axi_read_burst_buffer.sv
  - source/axi_burst_mem.sv
  - source/axi_rb_subsys.sv

  # testbench
  - target: test
    files:
      - test/axi_rb_checker.sv
      - test/tb_axi_rb_subsys.sv

// File: test/tb_axi_rb_subsys.sv
// ==========================================================
// testbench for the AXI4 read burst subsystem
// an AXI master model writes random bursts into a shadow
// copy, reads them back under several R stall patterns and
// checks data, latency, errors and the B hold behavior
// ==========================================================

`timescale 1ns/100ps

module tb_axi_rb_subsys;

  localparam int unsigned TIMEOUT_CYCLES = 200;

  typedef enum int {RD_STREAM, RD_HOLD, RD_GAPS, RD_RANDOM} rd_mode_e;

  logic                 clk;
  logic                 rst_n;
  axi_rb_pkg::ar_chan_t ar;
  logic                 ar_valid;
  logic                 ar_ready;
  axi_rb_pkg::aw_chan_t aw;
  logic                 aw_valid;
  logic                 aw_ready;
  axi_rb_pkg::w_chan_t  w;
  logic                 w_valid;
  logic                 w_ready;
  axi_rb_pkg::b_chan_t  b;
  logic                 b_valid;
  logic                 b_ready;
  axi_rb_pkg::r_chan_t  r;
  logic                 r_valid;
  logic                 r_ready;
  axi_rb_pkg::data_t    shadow [axi_rb_pkg::MEM_WORDS];
  int unsigned          err_cnt;
  int unsigned          chk_cnt;

  axi_rb_subsys u_axi_rb_subsys (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .slv_ar_i       (ar),
    .slv_ar_valid_i (ar_valid),
    .slv_ar_ready_o (ar_ready),
    .slv_aw_i       (aw),
    .slv_aw_valid_i (aw_valid),
    .slv_aw_ready_o (aw_ready),
    .slv_w_i        (w),
    .slv_w_valid_i  (w_valid),
    .slv_w_ready_o  (w_ready),
    .slv_b_o        (b),
    .slv_b_valid_o  (b_valid),
    .slv_b_ready_i  (b_ready),
    .slv_r_o        (r),
    .slv_r_valid_o  (r_valid),
    .slv_r_ready_i  (r_ready)
  );

  bind axi_rb_subsys axi_rb_checker u_checker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ar_i        (slv_ar_i),
    .ar_valid_i  (slv_ar_valid_i),
    .ar_ready_i  (slv_ar_ready_o),
    .aw_ready_i  (slv_aw_ready_o),
    .w_ready_i   (slv_w_ready_o),
    .b_i         (slv_b_o),
    .b_valid_i   (slv_b_valid_o),
    .b_ready_i   (slv_b_ready_i),
    .r_i         (slv_r_o),
    .r_valid_i   (slv_r_valid_o),
    .r_ready_i   (slv_r_ready_i),
    .mem_state_i (u_mem.state_q)
  );

  always #50 clk = ~clk;

  task automatic check_that(input bit ok, input string what);
    assert (ok) else begin
      err_cnt++;
      $display("error %0t: %s", $time, what);
    end
  endtask

  task automatic report_timeout(input string chan);
    err_cnt++;
    $display("timeout: no progress on the %s channel within %0d cycles", chan, TIMEOUT_CYCLES);
  endtask

  // one write burst; shadow takes the in-range bytes by strobe
  task automatic write_burst(input axi_rb_pkg::id_t id, input axi_rb_pkg::addr_t addr,
                             input int unsigned len, input bit full_strb,
                             input int unsigned b_hold);
    int unsigned       beat;
    int unsigned       wait_cnt;
    int unsigned       hold_left;
    axi_rb_pkg::addr_t a;
    axi_rb_pkg::resp_t exp_resp;
    bit                done;
    bit                load;
    exp_resp = axi_rb_pkg::RESP_OKAY;
    @(negedge clk);
    aw.id    = id;
    aw.addr  = addr;
    aw.len   = axi_rb_pkg::len_t'(len);
    aw_valid = 1'b1;
    done     = 1'b0;
    wait_cnt = 0;
    while (!done && wait_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      done = aw_ready;
      wait_cnt++;
    end
    if (!done) report_timeout("AW");
    beat     = 0;
    wait_cnt = 0;
    load     = 1'b1;
    while (beat <= len && wait_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      aw_valid = 1'b0;
      if (load) begin
        w.data  = $urandom();
        w.strb  = full_strb ? '1 : axi_rb_pkg::strb_t'($urandom());
        w.last  = (beat == len);
        w_valid = 1'b1;
        load    = 1'b0;
      end
      @(posedge clk);
      wait_cnt++;
      if (w_ready) begin
        a = addr + axi_rb_pkg::addr_t'(4 * beat);
        if (a >= axi_rb_pkg::MEM_BYTES) begin
          exp_resp = axi_rb_pkg::RESP_SLVERR;
        end else begin
          for (int i = 0; i < axi_rb_pkg::STRB_W; i++) begin
            if (w.strb[i]) shadow[a >> 2][8*i +: 8] = w.data[8*i +: 8];
          end
        end
        beat++;
        wait_cnt = 0;
        load     = 1'b1;
      end
    end
    if (beat <= len) report_timeout("W");
    @(negedge clk);
    w_valid   = 1'b0;
    b_ready   = (b_hold == 0);
    hold_left = b_hold;
    done      = 1'b0;
    wait_cnt  = 0;
    while (!done && wait_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      wait_cnt++;
      if (b_valid && b_ready) begin
        done = 1'b1;
        check_that(b.id == id, $sformatf("B id %0d, expected %0d", b.id, id));
        check_that(b.resp == exp_resp,
                   $sformatf("B resp %0d at 0x%0h, expected %0d", b.resp, addr, exp_resp));
      end else if (b_valid) begin
        // response held back by the master
        check_that(!aw_ready, "AW ready high while B is still pending");
        check_that(b.id == id, $sformatf("held B id %0d, expected %0d", b.id, id));
        if (hold_left > 0) hold_left--;
      end
      @(negedge clk);
      b_ready = !done && (hold_left == 0);
    end
    if (!done) report_timeout("B");
  endtask

  // one read burst, checked beat by beat against the shadow
  task automatic read_burst(input axi_rb_pkg::id_t id, input axi_rb_pkg::addr_t addr,
                            input int unsigned len, input rd_mode_e mode);
    int unsigned       beat;
    int unsigned       cyc;
    int unsigned       ar_cyc;
    int unsigned       wait_cnt;
    int unsigned       stall_left;
    bit                ar_done;
    bit                ar_back;
    bit                stalled;
    axi_rb_pkg::addr_t a;
    axi_rb_pkg::data_t exp_data;
    axi_rb_pkg::resp_t exp_resp;
    beat       = 0;
    cyc        = 0;
    ar_cyc     = 0;
    wait_cnt   = 0;
    stall_left = 0;
    ar_done    = 1'b0;
    ar_back    = (mode != RD_HOLD);
    stalled    = 1'b0;
    @(negedge clk);
    ar.id    = id;
    ar.addr  = addr;
    ar.len   = axi_rb_pkg::len_t'(len);
    ar_valid = 1'b1;
    r_ready  = (mode != RD_HOLD);
    while (beat <= len && wait_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cyc++;
      wait_cnt++;
      if (!ar_done) begin
        if (ar_ready) begin
          ar_done  = 1'b1;
          ar_cyc   = cyc;
          wait_cnt = 0;
        end
      end else if (!ar_back && ar_ready) begin
        // memory is free again while the burst sits in the buffer
        ar_back  = 1'b1;
        wait_cnt = 0;
      end
      if (r_valid && r_ready) begin
        a = addr + axi_rb_pkg::addr_t'(4 * beat);
        if (a >= axi_rb_pkg::MEM_BYTES) begin
          exp_data = '0;
          exp_resp = axi_rb_pkg::RESP_SLVERR;
        end else begin
          exp_data = shadow[a >> 2];
          exp_resp = axi_rb_pkg::RESP_OKAY;
        end
        check_that(r.data == exp_data && r.resp == exp_resp,
                   $sformatf("read 0x%0h beat %0d: data 0x%08h resp %0d, expected 0x%08h resp %0d",
                             addr, beat, r.data, r.resp, exp_data, exp_resp));
        check_that(r.id == id, $sformatf("R id %0d, expected %0d", r.id, id));
        check_that(r.last == (beat == len),
                   $sformatf("R last %0b on beat %0d of len %0d", r.last, beat, len));
        if (mode == RD_STREAM) begin
          check_that(cyc == ar_cyc + beat + 1,
                     $sformatf("beat %0d valid %0d cycles after AR, expected %0d",
                               beat, cyc - ar_cyc, beat + 1));
        end
        beat++;
        wait_cnt = 0;
      end
      @(negedge clk);
      if (ar_done) ar_valid = 1'b0;
      case (mode)
        RD_STREAM: r_ready = 1'b1;
        RD_HOLD:   r_ready = ar_back;
        default: begin
          if (mode == RD_GAPS && beat == 2 && !stalled) begin
            stalled    = 1'b1;
            stall_left = axi_rb_pkg::BUF_DEPTH + 4;
          end
          if (stall_left > 0) begin
            r_ready = 1'b0;
            stall_left--;
          end else begin
            r_ready = ($urandom_range(3, 0) != 0);
          end
        end
      endcase
    end
    if (!ar_done) report_timeout("AR");
    else if (!ar_back) report_timeout("AR (ready after the buffered burst)");
    else if (beat <= len) report_timeout("R");
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    @(posedge clk);
    check_that(!r_valid, $sformatf("extra R beat after the burst at 0x%0h", addr));
  endtask

  initial begin
    int unsigned       len;
    axi_rb_pkg::addr_t addr;
    err_cnt  = 0;
    void'($urandom(32'hd0fe_b312));
    clk      = 1'b0;
    rst_n    = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // fill every word with full strobes
    for (int i = 0; i < axi_rb_pkg::MEM_WORDS / 16; i++) begin
      write_burst(axi_rb_pkg::id_t'(i), axi_rb_pkg::addr_t'(i * 64), 15, 1'b1, 0);
    end

    // random bursts with random strobes, then read back
    for (int i = 0; i < 12; i++) begin
      len  = $urandom_range(axi_rb_pkg::MAX_LEN, 0);
      addr = axi_rb_pkg::addr_t'(4 * $urandom_range(axi_rb_pkg::MEM_WORDS - 1 - len, 0));
      write_burst(axi_rb_pkg::id_t'($urandom()), addr, len, 1'b0, $urandom_range(3, 0));
      read_burst(axi_rb_pkg::id_t'($urandom()), addr, len, RD_RANDOM);
    end

    // latency with R ready held high
    read_burst(4'h3, 32'h0000_0000, 15, RD_STREAM);
    read_burst(4'h5, 32'h0000_0100, 0, RD_STREAM);

    // whole burst parked in the buffer
    read_burst(4'h7, 32'h0000_0200, axi_rb_pkg::BUF_DEPTH - 1, RD_HOLD);

    // long R stalls beyond the buffer depth
    for (int i = 0; i < 3; i++) begin
      addr = axi_rb_pkg::addr_t'(4 * $urandom_range(axi_rb_pkg::MEM_WORDS - 16, 0));
      read_burst(axi_rb_pkg::id_t'($urandom()), addr, 15, RD_GAPS);
    end

    // out of range accesses
    write_burst(4'h9, axi_rb_pkg::MEM_BYTES, 3, 1'b1, 2);
    write_burst(4'ha, axi_rb_pkg::MEM_BYTES - 4, 1, 1'b1, 0);
    read_burst(4'hb, axi_rb_pkg::MEM_BYTES, 3, RD_STREAM);
    read_burst(4'hc, axi_rb_pkg::MEM_BYTES - 8, 3, RD_RANDOM);
    read_burst(4'hd, 32'h0000_0000, 0, RD_STREAM);

    // B held back by the master
    for (int i = 0; i < 4; i++) begin
      len  = $urandom_range(axi_rb_pkg::MAX_LEN, 0);
      addr = axi_rb_pkg::addr_t'(4 * $urandom_range(axi_rb_pkg::MEM_WORDS - 1 - len, 0));
      write_burst(axi_rb_pkg::id_t'($urandom()), addr, len, 1'b0, $urandom_range(20, 1));
      read_burst(axi_rb_pkg::id_t'($urandom()), addr, len, RD_STREAM);
    end

    chk_cnt = u_axi_rb_subsys.u_checker.fail_cnt;
    $display("errors: %0d in testbench checks, %0d in protocol assertions", err_cnt, chk_cnt);
    if (err_cnt + chk_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: test/axi_rb_checker.sv
// ==========================================================
// protocol assertions on the upstream AXI4 port of the
// read burst subsystem, bound into the subsystem top
// fail_cnt counts assertion failures for the testbench
// ==========================================================

`timescale 1ns/100ps

module axi_rb_checker (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input axi_rb_pkg::ar_chan_t   ar_i,
  input logic                   ar_valid_i,
  input logic                   ar_ready_i,
  input logic                   aw_ready_i,
  input logic                   w_ready_i,
  input axi_rb_pkg::b_chan_t    b_i,
  input logic                   b_valid_i,
  input logic                   b_ready_i,
  input axi_rb_pkg::r_chan_t    r_i,
  input logic                   r_valid_i,
  input logic                   r_ready_i,
  input axi_rb_pkg::mem_state_e mem_state_i
);

  int unsigned      fail_cnt = 0;

  // len of each accepted AR in order
  axi_rb_pkg::len_t len_mem [16];
  logic [3:0]       len_wr_q;
  logic [3:0]       len_rd_q;
  axi_rb_pkg::len_t beat_q;
  logic             exp_last;

  assign exp_last = (beat_q == len_mem[len_rd_q]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      len_wr_q <= '0;
      len_rd_q <= '0;
      beat_q   <= '0;
    end else begin
      if (ar_valid_i && ar_ready_i) begin
        len_mem[len_wr_q] <= ar_i.len;
        len_wr_q          <= len_wr_q + 1'b1;
      end
      if (r_valid_i && r_ready_i) begin
        if (exp_last) begin
          beat_q   <= '0;
          len_rd_q <= len_rd_q + 1'b1;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end
    end
  end

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else begin
      fail_cnt++;
      $error("R valid dropped or R payload changed before acceptance");
    end

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else begin
      fail_cnt++;
      $error("B valid dropped or B payload changed before acceptance");
    end

  // outputs settle to their idle values once reset is sampled
  reset_values: assert property (@(posedge clk_i)
    !rst_n_i |=> !r_valid_i && !b_valid_i && ar_ready_i && !w_ready_i
                 && (aw_ready_i || ar_valid_i))
    else begin
      fail_cnt++;
      $error("outputs not at their reset values during reset");
    end

  // a beat the memory offers is visible upstream in the same cycle
  r_valid_in_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_state_i == axi_rb_pkg::READ |-> r_valid_i)
    else begin
      fail_cnt++;
      $error("memory offers an R beat that the upstream R channel does not show");
    end

  r_last_beat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_i |-> r_i.last == exp_last)
    else begin
      fail_cnt++;
      $error("R last does not mark beat len+1 of the burst");
    end

endmodule

// File: source/axi_rb_subsys.sv
// ==========================================================
// subsystem top: R burst buffer in front of the burst memory
// one AXI4 slave port faces the upstream master
// ==========================================================

`timescale 1ns/100ps

module axi_rb_subsys (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  axi_rb_pkg::ar_chan_t slv_ar_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  input  axi_rb_pkg::aw_chan_t slv_aw_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  axi_rb_pkg::w_chan_t  slv_w_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  output axi_rb_pkg::b_chan_t  slv_b_o,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  output axi_rb_pkg::r_chan_t  slv_r_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i
);

  // buffer to memory
  axi_rb_pkg::ar_chan_t mem_ar;
  axi_rb_pkg::aw_chan_t mem_aw;
  axi_rb_pkg::w_chan_t  mem_w;
  axi_rb_pkg::b_chan_t  mem_b;
  axi_rb_pkg::r_chan_t  mem_r;
  logic mem_ar_valid, mem_ar_ready;
  logic mem_aw_valid, mem_aw_ready;
  logic mem_w_valid,  mem_w_ready;
  logic mem_b_valid,  mem_b_ready;
  logic mem_r_valid,  mem_r_ready;

  axi_read_burst_buffer u_buffer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_w_i        (slv_w_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_b_o        (slv_b_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .mst_ar_o       (mem_ar),
    .mst_ar_valid_o (mem_ar_valid),
    .mst_ar_ready_i (mem_ar_ready),
    .mst_aw_o       (mem_aw),
    .mst_aw_valid_o (mem_aw_valid),
    .mst_aw_ready_i (mem_aw_ready),
    .mst_w_o        (mem_w),
    .mst_w_valid_o  (mem_w_valid),
    .mst_w_ready_i  (mem_w_ready),
    .mst_b_i        (mem_b),
    .mst_b_valid_i  (mem_b_valid),
    .mst_b_ready_o  (mem_b_ready),
    .mst_r_i        (mem_r),
    .mst_r_valid_i  (mem_r_valid),
    .mst_r_ready_o  (mem_r_ready)
  );

  axi_burst_mem u_mem (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_ar_i       (mem_ar),
    .slv_ar_valid_i (mem_ar_valid),
    .slv_ar_ready_o (mem_ar_ready),
    .slv_aw_i       (mem_aw),
    .slv_aw_valid_i (mem_aw_valid),
    .slv_aw_ready_o (mem_aw_ready),
    .slv_w_i        (mem_w),
    .slv_w_valid_i  (mem_w_valid),
    .slv_w_ready_o  (mem_w_ready),
    .slv_b_o        (mem_b),
    .slv_b_valid_o  (mem_b_valid),
    .slv_b_ready_i  (mem_b_ready),
    .slv_r_o        (mem_r),
    .slv_r_valid_o  (mem_r_valid),
    .slv_r_ready_i  (mem_r_ready)
  );

endmodule

// File: source/axi_burst_mem.sv
// ==========================================================
// AXI4 memory slave with 256 words of 32 bits
// serves one INCR burst at a time, read or write; AR wins
// over AW in the same cycle, and beats beyond the memory
// range answer SLVERR without touching the array
// ==========================================================

`timescale 1ns/100ps

module axi_burst_mem (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  axi_rb_pkg::ar_chan_t slv_ar_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  input  axi_rb_pkg::aw_chan_t slv_aw_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  axi_rb_pkg::w_chan_t  slv_w_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  output axi_rb_pkg::b_chan_t  slv_b_o,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  output axi_rb_pkg::r_chan_t  slv_r_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i
);

  axi_rb_pkg::mem_state_e state_q;
  axi_rb_pkg::data_t      mem_q [axi_rb_pkg::MEM_WORDS];
  axi_rb_pkg::addr_t      addr_q;
  axi_rb_pkg::len_t       rem_q;
  axi_rb_pkg::id_t        id_q;
  axi_rb_pkg::word_idx_t  word_idx;
  logic                   len_err_q;
  logic                   wr_err_q;
  logic                   beat_err;
  logic                   ar_hs;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   r_hs;
  logic                   b_hs;

  // handshakes; AW waits while an AR is offered
  assign slv_ar_ready_o = (state_q == axi_rb_pkg::IDLE);
  assign slv_aw_ready_o = (state_q == axi_rb_pkg::IDLE) & ~slv_ar_valid_i;
  assign slv_w_ready_o  = (state_q == axi_rb_pkg::WRITE);
  assign slv_r_valid_o  = (state_q == axi_rb_pkg::READ);
  assign slv_b_valid_o  = (state_q == axi_rb_pkg::BRESP);

  assign ar_hs = slv_ar_valid_i & slv_ar_ready_o;
  assign aw_hs = slv_aw_valid_i & slv_aw_ready_o;
  assign w_hs  = slv_w_valid_i & slv_w_ready_o;
  assign r_hs  = slv_r_valid_o & slv_r_ready_i;
  assign b_hs  = slv_b_valid_o & slv_b_ready_i;

  // current beat: word index and range check
  assign word_idx = addr_q[axi_rb_pkg::MEM_IDX_W+1:2];
  assign beat_err = len_err_q | (addr_q >= axi_rb_pkg::addr_t'(axi_rb_pkg::MEM_BYTES));

  always_comb begin
    slv_r_o.id   = id_q;
    slv_r_o.data = beat_err ? '0 : mem_q[word_idx];
    slv_r_o.resp = beat_err ? axi_rb_pkg::RESP_SLVERR : axi_rb_pkg::RESP_OKAY;
    slv_r_o.last = (rem_q == '0);
  end

  assign slv_b_o.id   = id_q;
  assign slv_b_o.resp = wr_err_q ? axi_rb_pkg::RESP_SLVERR : axi_rb_pkg::RESP_OKAY;

  // control FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= axi_rb_pkg::IDLE;
      len_err_q <= 1'b0;
      wr_err_q  <= 1'b0;
    end else begin
      case (state_q)
        axi_rb_pkg::IDLE: begin
          if (ar_hs) begin
            state_q   <= axi_rb_pkg::READ;
            len_err_q <= (slv_ar_i.len > axi_rb_pkg::MAX_LEN);
          end else if (aw_hs) begin
            state_q   <= axi_rb_pkg::WRITE;
            len_err_q <= (slv_aw_i.len > axi_rb_pkg::MAX_LEN);
            wr_err_q  <= 1'b0;
          end
        end
        axi_rb_pkg::READ: begin
          // leave as soon as the last beat is taken
          if (r_hs && rem_q == '0) begin
            state_q <= axi_rb_pkg::IDLE;
          end
        end
        axi_rb_pkg::WRITE: begin
          if (w_hs) begin
            wr_err_q <= wr_err_q | beat_err;
            if (slv_w_i.last) begin
              state_q <= axi_rb_pkg::BRESP;
            end
          end
        end
        axi_rb_pkg::BRESP: begin
          if (b_hs) begin
            state_q <= axi_rb_pkg::IDLE;
          end
        end
        default: state_q <= axi_rb_pkg::IDLE;
      endcase
    end
  end

  // burst address, beat counter and ID
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      addr_q <= slv_ar_i.addr;
      rem_q  <= slv_ar_i.len;
      id_q   <= slv_ar_i.id;
    end else if (aw_hs) begin
      addr_q <= slv_aw_i.addr;
      rem_q  <= slv_aw_i.len;
      id_q   <= slv_aw_i.id;
    end else if (r_hs || w_hs) begin
      addr_q <= addr_q + axi_rb_pkg::addr_t'(4);
      rem_q  <= rem_q - 1'b1;
    end
  end

  // byte-wise write, skipped for beats in error
  always_ff @(posedge clk_i) begin
    if (w_hs && !beat_err) begin
      for (int b = 0; b < axi_rb_pkg::STRB_W; b++) begin
        if (slv_w_i.strb[b]) begin
          mem_q[word_idx][8*b +: 8] <= slv_w_i.data[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: source/axi_read_burst_buffer.sv
// ==========================================================
// R burst buffer between an upstream master and a slave
// R beats from the slave land in a fall-through FIFO, so a
// stalled upstream does not hold the slave's R channel
// AR, AW, W and B are wired straight through
// ==========================================================

`timescale 1ns/100ps

module axi_read_burst_buffer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // upstream side
  input  axi_rb_pkg::ar_chan_t slv_ar_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  input  axi_rb_pkg::aw_chan_t slv_aw_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  axi_rb_pkg::w_chan_t  slv_w_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  output axi_rb_pkg::b_chan_t  slv_b_o,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  output axi_rb_pkg::r_chan_t  slv_r_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,

  // memory side
  output axi_rb_pkg::ar_chan_t mst_ar_o,
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  output axi_rb_pkg::aw_chan_t mst_aw_o,
  output logic                 mst_aw_valid_o,
  input  logic                 mst_aw_ready_i,
  output axi_rb_pkg::w_chan_t  mst_w_o,
  output logic                 mst_w_valid_o,
  input  logic                 mst_w_ready_i,
  input  axi_rb_pkg::b_chan_t  mst_b_i,
  input  logic                 mst_b_valid_i,
  output logic                 mst_b_ready_o,
  input  axi_rb_pkg::r_chan_t  mst_r_i,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o
);

  logic buf_full;
  logic buf_empty;

  rb_fifo #(
    .DEPTH (axi_rb_pkg::BUF_DEPTH)
  ) u_r_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (mst_r_valid_i & mst_r_ready_o),
    .data_i  (mst_r_i),
    .full_o  (buf_full),
    .pop_i   (slv_r_valid_o & slv_r_ready_i),
    .empty_o (buf_empty),
    .data_o  (slv_r_o)
  );

  // slave side keeps streaming as long as there is room
  assign mst_r_ready_o = ~buf_full;
  assign slv_r_valid_o = ~buf_empty;

  // other channels pass through
  assign mst_ar_o       = slv_ar_i;
  assign mst_ar_valid_o = slv_ar_valid_i;
  assign slv_ar_ready_o = mst_ar_ready_i;
  assign mst_aw_o       = slv_aw_i;
  assign mst_aw_valid_o = slv_aw_valid_i;
  assign slv_aw_ready_o = mst_aw_ready_i;
  assign mst_w_o        = slv_w_i;
  assign mst_w_valid_o  = slv_w_valid_i;
  assign slv_w_ready_o  = mst_w_ready_i;
  assign slv_b_o        = mst_b_i;
  assign slv_b_valid_o  = mst_b_valid_i;
  assign mst_b_ready_o  = slv_b_ready_i;

endmodule

// File: source/rb_fifo.sv
// ==========================================================
// fall-through FIFO for R channel beats
// while empty the input beat shows on the output in the same
// cycle, so an idle buffer adds no latency
// ==========================================================

`timescale 1ns/100ps

module rb_fifo #(
  parameter int unsigned DEPTH = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  axi_rb_pkg::r_chan_t data_i,
  output logic                full_o,
  input  logic                pop_i,
  output logic                empty_o,
  output axi_rb_pkg::r_chan_t data_o
);

  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH):0]   cnt_q;
  axi_rb_pkg::r_chan_t      buf_q [DEPTH];
  logic                     bypass;
  logic                     do_push;
  logic                     do_pop;

  // circular pointer step
  function automatic logic [$clog2(DEPTH)-1:0] next_ptr(input logic [$clog2(DEPTH)-1:0] ptr);
    if (ptr == DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign bypass  = (cnt_q == '0);
  assign full_o  = (cnt_q == DEPTH);
  // a push into an empty FIFO is already visible
  assign empty_o = bypass & ~push_i;
  assign data_o  = bypass ? data_i : buf_q[rd_ptr_q];

  // a beat that passes straight through is not stored
  assign do_push = push_i & ~full_o & ~(bypass & pop_i);
  assign do_pop  = pop_i & ~bypass;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10: cnt_q <= cnt_q + 1'b1;
        2'b01: cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      buf_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: source/axi_rb_pkg.sv
// ==========================================================
// shared widths, channel payload types and constants for the
// AXI4 read burst buffer subsystem
// every design and test file refers to these by scoped name
// ==========================================================

package axi_rb_pkg;

  // field widths
  localparam int unsigned ID_W   = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned RESP_W = 2;

  // memory geometry
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MEM_BYTES = MEM_WORDS * STRB_W;
  localparam int unsigned MEM_IDX_W = $clog2(MEM_WORDS);

  // burst buffer depth in R beats
  localparam int unsigned BUF_DEPTH = 8;

  // largest len the memory serves, i.e. 16 beats
  localparam int unsigned MAX_LEN = 15;

  typedef logic [ID_W-1:0]      id_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [STRB_W-1:0]    strb_t;
  typedef logic [LEN_W-1:0]     len_t;
  typedef logic [RESP_W-1:0]    resp_t;
  typedef logic [MEM_IDX_W-1:0] word_idx_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  typedef enum logic [1:0] {IDLE, READ, WRITE, BRESP} mem_state_e;

endpackage
